//--- src/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Clock cycles per instruction in multiples of 4 and never below 4
`define CORE_CPI 8

// Each of the four steps gets an equal share of the instruction period
`define CORE_STEP (`CORE_CPI / 4)

// First fetch address after reset
`define RESET_VECTOR 32'h0000_0000

// All-zero word decodes as r0 <- r0 | r0 + 0, so nothing changes
`define INSN_NOOP 32'h0000_0000

`endif

//--- src/isaPkg.sv
`default_nettype none

package isaPkg;

    typedef enum logic [3:0] {
        opOr    = 4'h0,
        opAnd   = 4'h1,
        opAdd   = 4'h2,
        opMul   = 4'h3,
        opRsvd4 = 4'h4,             // Reserved code yields zero
        opShl   = 4'h5,
        opLt    = 4'h6,
        opEq    = 4'h7,
        opGt    = 4'h8,
        opAndn  = 4'h9,             // X and not Y
        opXor   = 4'ha,
        opSub   = 4'hb,
        opXnor  = 4'hc,
        opShr   = 4'hd,             // Logical shift
        opNe    = 4'he,
        opRsvdF = 4'hf              // Reserved code yields zero
    } aluOp;

    typedef logic [3:0] regIndex;

    // Single instruction layout with the MSB first
    typedef struct packed {
        logic       spare;
        logic       typeSwap;       // Swap Y and immediate roles
        logic       storing;
        logic       derefRhs;       // Right-hand side goes through memory
        regIndex    z;
        regIndex    x;
        regIndex    y;
        aluOp       op;
        logic [11:0] imm;
    } instrFields;

endpackage

`default_nettype wire

//--- src/busPkg.sv
`default_nettype none

package busPkg;

    // Four equal steps of one instruction period
    typedef enum logic [1:0] {
        stepFetch     = 2'd0,
        stepExecute   = 2'd1,
        stepMemory    = 2'd2,
        stepWriteback = 2'd3
    } coreStep;

    typedef enum logic [1:0] {
        accessNone       = 2'd0,
        accessLoad       = 2'd1,
        accessStoreToZ   = 2'd2,   // Address from Z, data from ALU
        accessStoreToRhs = 2'd3    // Address from ALU, data from Z
    } accessKind;

endpackage

`default_nettype wire

//--- src/instrDecoder.sv
`default_nettype none
`timescale 1ns/10ps

module instrDecoder
    import isaPkg::*;
(
    input  instrFields  instrWord,
    output regIndex     indexX,
    output regIndex     indexY,
    output regIndex     indexZ,
    output aluOp        op,
    output logic [31:0] immExt,
    output logic        typeSwap,
    output logic        storing,
    output logic        derefRhs,
    output logic        illegal,
    output logic        branching
);

    assign indexX   = instrWord.x;
    assign indexY   = instrWord.y;
    assign indexZ   = instrWord.z;
    assign op       = instrWord.op;
    assign typeSwap = instrWord.typeSwap;
    assign storing  = instrWord.storing;
    assign derefRhs = instrWord.derefRhs;

    assign immExt    = {{20{instrWord.imm[11]}}, instrWord.imm};  // Sign extend
    assign illegal   = &instrWord;                                // All-ones word
    assign branching = (&instrWord.z) && !instrWord.storing;     // Write to r15

endmodule

`default_nettype wire

//--- src/registerFile.sv
`default_nettype none
`timescale 1ns/10ps

module registerFile
    import isaPkg::*;
(
    input  logic        clk,
    input  regIndex     indexX,
    input  regIndex     indexY,
    input  regIndex     indexZ,
    input  logic        writeEnable,
    input  logic [31:0] writeValue,
    input  logic [31:0] nextPc,
    output logic [31:0] valueX,
    output logic [31:0] valueY,
    output logic [31:0] valueZ
);

    logic [31:0] regs [1:14];  // r0 and r15 have no storage

    function automatic logic [31:0] readPort(regIndex index);
        if (index == 4'd0)
            return '0;
        if (index == 4'd15)
            return nextPc;         // r15 reads the next instruction address
        return regs[index];
    endfunction

    assign valueX = readPort(indexX);
    assign valueY = readPort(indexY);
    assign valueZ = readPort(indexZ);

    always_ff @(posedge clk) begin
        if (writeEnable && indexZ != 4'd0 && indexZ != 4'd15)
            regs[indexZ] <= writeValue;
    end

endmodule

`default_nettype wire

//--- src/aluExec.sv
`default_nettype none
`timescale 1ns/10ps

module aluExec
    import isaPkg::*,
           busPkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  coreStep     step,
    input  logic        stepStart,
    input  aluOp        op,
    input  logic        typeSwap,
    input  logic [31:0] valueX,
    input  logic [31:0] valueY,
    input  logic [31:0] immExt,
    output logic [31:0] aluResult
);

    logic signed [31:0] lhs;
    logic signed [31:0] operand;
    logic [31:0]        addend;
    logic [31:0]        opValue;
    logic [31:0]        opResult;

    assign lhs     = valueX;
    assign operand = typeSwap ? immExt : valueY;  // Type 1 takes I as operand
    assign addend  = typeSwap ? valueY : immExt;

    always_comb begin
        case (op)
            opOr:    opValue = lhs | operand;
            opAnd:   opValue = lhs & operand;
            opAdd:   opValue = lhs + operand;
            opMul:   opValue = lhs * operand;
            opShl:   opValue = lhs << operand;
            opLt:    opValue = {32{lhs < operand}};
            opEq:    opValue = {32{lhs == operand}};
            opGt:    opValue = {32{lhs > operand}};
            opAndn:  opValue = lhs & ~operand;
            opXor:   opValue = lhs ^ operand;
            opSub:   opValue = lhs - operand;
            opXnor:  opValue = lhs ~^ operand;
            opShr:   opValue = $unsigned(lhs) >> operand;
            opNe:    opValue = {32{lhs != operand}};
            default: opValue = '0;                 // Reserved codes
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n)
            opResult <= '0;
        else if (step == stepExecute && stepStart)
            opResult <= opValue;                   // Sampled once per instruction
    end

    assign aluResult = opResult + addend;

endmodule

`default_nettype wire

//--- src/coreControl.sv
`default_nettype none
`timescale 1ns/10ps
`include "core_params.svh"

module coreControl
    import busPkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic [31:0] instrData,
    input  logic [31:0] aluResult,
    input  logic [31:0] valueZ,
    input  logic [31:0] dataIn,
    input  logic        storing,
    input  logic        derefRhs,
    input  logic        illegal,
    input  logic        branching,
    output logic [31:0] instrWord,
    output coreStep     step,
    output logic        stepStart,
    output logic [31:0] instrAddr,
    output logic [31:0] nextPc,
    output logic [31:0] writeValue,
    output logic [31:0] dataAddr,
    output logic [31:0] dataOut,
    output logic        writeEnable,
    output logic        strobe,
    output logic        rw,
    output logic        halt
);

    localparam int countWidth = $clog2(`CORE_CPI);
    localparam logic [countWidth-1:0] stepLength = countWidth'(`CORE_STEP);
    localparam logic [countWidth-1:0] loadSlot   = countWidth'(`CORE_STEP + 1);
    localparam logic [countWidth-1:0] memStart   = countWidth'(2 * `CORE_STEP);
    localparam logic [countWidth-1:0] wbStart    = countWidth'(3 * `CORE_STEP);
    localparam logic [countWidth-1:0] lastCycle  = countWidth'(`CORE_CPI - 1);

    logic [countWidth-1:0] cycleCount;
    logic                  running;       // Low for the idle cycle after reset
    logic [31:0]           loadData;
    logic [31:0]           rhs;
    accessKind             kind;

    assign step      = coreStep'(2'(cycleCount / stepLength));
    assign stepStart = running && (cycleCount % stepLength) == '0;

    always_comb begin
        if (storing)
            kind = derefRhs ? accessStoreToRhs : accessStoreToZ;
        else if (derefRhs)
            kind = accessLoad;
        else
            kind = accessNone;
    end

    assign rhs        = (kind == accessLoad) ? loadData : aluResult;
    assign writeValue = rhs;
    assign dataAddr   = (kind == accessStoreToZ) ? valueZ : aluResult;
    assign dataOut    = (kind == accessStoreToRhs) ? valueZ : aluResult;

    // Load in the second cycle of execute, store in the first cycle of memory
    assign strobe = running && !halt &&
                    ((kind == accessLoad && cycleCount == loadSlot) ||
                     (storing && cycleCount == memStart));
    assign rw          = strobe && storing;
    assign writeEnable = running && !halt && !storing && cycleCount == lastCycle;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            running    <= 1'b0;
            cycleCount <= '0;
            instrWord  <= `INSN_NOOP;
            instrAddr  <= `RESET_VECTOR;
            nextPc     <= `RESET_VECTOR + 32'd1;
            halt       <= 1'b0;
        end else begin
            running <= 1'b1;
            if (running) begin
                cycleCount <= (cycleCount == lastCycle) ? '0 : cycleCount + 1'b1;
                if (cycleCount == '0)
                    instrWord <= instrData;                 // Fetch
                if (cycleCount == stepLength)
                    halt <= halt | illegal;                 // Sticky once set
                if (cycleCount == memStart && !halt)
                    instrAddr <= branching ? rhs : nextPc;  // Jump on r15 write
                if (cycleCount == wbStart)
                    nextPc <= instrAddr + 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (running && cycleCount == loadSlot)
            loadData <= dataIn;
    end

endmodule

`default_nettype wire

//--- src/coreTop.sv
`default_nettype none
`timescale 1ns/10ps

module coreTop
    import isaPkg::*,
           busPkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    output logic [31:0] instrAddr,
    input  logic [31:0] instrData,
    output logic [31:0] dataAddr,
    output logic [31:0] dataOut,
    input  logic [31:0] dataIn,
    output logic        strobe,
    output logic        rw,
    output logic        halt
);

    logic [31:0] instrWord;
    regIndex     indexX;
    regIndex     indexY;
    regIndex     indexZ;
    aluOp        op;
    logic [31:0] immExt;
    logic        typeSwap;
    logic        storing;
    logic        derefRhs;
    logic        illegal;
    logic        branching;
    logic [31:0] valueX;
    logic [31:0] valueY;
    logic [31:0] valueZ;
    logic [31:0] aluResult;
    logic [31:0] writeValue;
    logic [31:0] nextPc;
    logic        writeEnable;
    coreStep     step;
    logic        stepStart;

    instrDecoder instrDecoder_inst (
        .instrWord (instrWord), .indexX   (indexX),   .indexY    (indexY),
        .indexZ    (indexZ),    .op       (op),       .immExt    (immExt),
        .typeSwap  (typeSwap),  .storing  (storing),  .derefRhs  (derefRhs),
        .illegal   (illegal),   .branching(branching)
    );

    registerFile registerFile_inst (
        .clk        (clk),         .indexX     (indexX),     .indexY (indexY),
        .indexZ     (indexZ),      .writeEnable(writeEnable),
        .writeValue (writeValue),  .nextPc     (nextPc),
        .valueX     (valueX),      .valueY     (valueY),     .valueZ (valueZ)
    );

    aluExec aluExec_inst (
        .clk      (clk),       .reset_n  (reset_n),  .step     (step),
        .stepStart(stepStart), .op       (op),       .typeSwap (typeSwap),
        .valueX   (valueX),    .valueY   (valueY),   .immExt   (immExt),
        .aluResult(aluResult)
    );

    coreControl coreControl_inst (
        .clk        (clk),        .reset_n   (reset_n),   .instrData (instrData),
        .aluResult  (aluResult),  .valueZ    (valueZ),    .dataIn    (dataIn),
        .storing    (storing),    .derefRhs  (derefRhs),  .illegal   (illegal),
        .branching  (branching),  .instrWord (instrWord), .step      (step),
        .stepStart  (stepStart),  .instrAddr (instrAddr), .nextPc    (nextPc),
        .writeValue (writeValue), .dataAddr  (dataAddr),  .dataOut   (dataOut),
        .writeEnable(writeEnable), .strobe   (strobe),    .rw        (rw),
        .halt       (halt)
    );

endmodule

`default_nettype wire

//--- test/clockGen.sv
`default_nettype none
`timescale 1ns/10ps

module clockGen (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;    // 20 ns period
    end

    initial begin
        reset_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;            // Released on a falling edge
    end

endmodule

`default_nettype wire

//--- test/simMemory.sv
`default_nettype none
`timescale 1ns/10ps

module simMemory (
    input  logic        clk,
    input  logic [31:0] instrAddr,
    output logic [31:0] instrData,
    input  logic [31:0] dataAddr,
    input  logic [31:0] dataOut,
    output logic [31:0] dataIn,
    input  logic        strobe,
    input  logic        rw,
    input  logic        loadEnable,
    input  logic [31:0] loadAddr,
    input  logic [31:0] loadData
);

    localparam int depth = 1024;

    logic [31:0] words [0:depth-1];

    // Each word decodes as r15 <- own address, so the core parks wherever it lands
    initial begin
        for (int i = 0; i < depth; i++)
            words[i] = 32'h0f00_0000 | 32'(i);
    end

    assign instrData = words[instrAddr[9:0]];
    assign dataIn    = words[dataAddr[9:0]];

    always @(posedge clk) begin
        if (strobe && rw)
            words[dataAddr[9:0]] <= dataOut;     // Core store
        if (loadEnable)
            words[loadAddr[9:0]] <= loadData;    // Program and data loading
    end

endmodule

`default_nettype wire

//--- test/coreTb.sv
`default_nettype none
`timescale 1ns/10ps
`include "core_params.svh"

module coreTb
    import isaPkg::*;
();

    localparam int resultAddr    = 1000;
    localparam int testInstrs    = 120;
    localparam int launches      = 6;
    localparam int holdPeriods   = 4;
    localparam int loaderWrites  = 195;
    localparam int timeoutCycles =
        ((testInstrs + launches + holdPeriods) * `CORE_CPI + loaderWrites + 6) * 3 / 2;

    logic        clk;
    logic        reset_n;
    logic [31:0] instrAddr;
    logic [31:0] instrData;
    logic [31:0] dataAddr;
    logic [31:0] dataOut;
    logic [31:0] dataIn;
    logic        strobe;
    logic        rw;
    logic        halt;
    logic        loadEnable;
    logic [31:0] loadAddr;
    logic [31:0] loadData;
    logic [31:0] lfsrState;
    int          progPtr;
    int          parkAddr;
    int          cycleCount = 0;

    clockGen clockGen_inst (.clk(clk), .reset_n(reset_n));

    coreTop coreTop_inst (
        .clk      (clk),      .reset_n  (reset_n),  .instrAddr(instrAddr),
        .instrData(instrData), .dataAddr (dataAddr), .dataOut  (dataOut),
        .dataIn   (dataIn),   .strobe   (strobe),   .rw       (rw),
        .halt     (halt)
    );

    simMemory simMemory_inst (
        .clk      (clk),      .instrAddr (instrAddr),  .instrData(instrData),
        .dataAddr (dataAddr), .dataOut   (dataOut),    .dataIn   (dataIn),
        .strobe   (strobe),   .rw        (rw),         .loadEnable(loadEnable),
        .loadAddr (loadAddr), .loadData  (loadData)
    );

    function automatic logic [31:0] encode(int swap, int store, int deref, int z, int x,
                                           int y, aluOp op, int imm);
        return {1'b0, 1'(swap), 1'(store), 1'(deref), 4'(z), 4'(x), 4'(y), op, 12'(imm)};
    endfunction

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] randomBits(int width);
        logic [31:0] value;
        int          i;
        value = '0;
        for (i = 0; i < width; i++) begin
            value     = {value[30:0], lfsrState[0]};
            lfsrState = (lfsrState >> 1) ^ (lfsrState[0] ? 32'h8020_0003 : 32'h0);
        end
        return value;
    endfunction

    // X op Y + I for type 0, X op I + Y for type 1
    function automatic logic [31:0] aluModel(aluOp op, int swap, logic [31:0] x,
                                             logic [31:0] y, logic [31:0] imm);
        logic [31:0] b;
        logic [31:0] r;
        b = (swap != 0) ? imm : y;
        case (op)
            opOr:    r = x | b;
            opAnd:   r = x & b;
            opAdd:   r = x + b;
            opMul:   r = x * b;
            opShl:   r = (b < 32) ? x << b[4:0] : 32'h0;
            opLt:    r = ($signed(x) < $signed(b)) ? '1 : '0;
            opEq:    r = (x == b) ? '1 : '0;
            opGt:    r = ($signed(x) > $signed(b)) ? '1 : '0;
            opAndn:  r = x & ~b;
            opXor:   r = x ^ b;
            opSub:   r = x - b;
            opXnor:  r = ~(x ^ b);
            opShr:   r = (b < 32) ? x >> b[4:0] : 32'h0;
            opNe:    r = (x != b) ? '1 : '0;
            default: r = '0;
        endcase
        return r + ((swap != 0) ? y : imm);
    endfunction

    task automatic stopWithFailure();
        $display("TB FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic checkValue(string name, logic [31:0] got, logic [31:0] want);
        assert (got === want) else begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, want);
            stopWithFailure();
        end
    endtask

    task automatic writeWord(int addr, logic [31:0] word);
        @(negedge clk);
        loadEnable = 1'b1;
        loadAddr   = 32'(addr);
        loadData   = word;
    endtask

    task automatic emit(logic [31:0] word);
        writeWord(progPtr, word);
        progPtr++;
    endtask

    // Opens the parking loop so the core runs into the new program
    task automatic launch();
        writeWord(parkAddr, `INSN_NOOP);
        @(negedge clk);
        loadEnable = 1'b0;
        parkAddr   = progPtr;
        progPtr++;
    endtask

    task automatic expectAccess(int isStore, int addr, logic [31:0] data);
        @(negedge clk);
        while (!strobe)
            @(negedge clk);
        checkValue("rw", 32'(rw), 32'(isStore));
        checkValue("dataAddr", dataAddr, 32'(addr));
        if (isStore != 0)
            checkValue("dataOut", dataOut, data);
    endtask

    task automatic resetSequence();
        logic [31:0] lastAddr;
        int          i;
        @(negedge clk);
        while (!reset_n)
            @(negedge clk);
        checkValue("instrAddr", instrAddr, `RESET_VECTOR);
        checkValue("strobe", 32'(strobe), 32'h0);
        checkValue("rw", 32'(rw), 32'h0);
        checkValue("halt", 32'(halt), 32'h0);
        for (i = 0; i < 4; i++)
            emit(`INSN_NOOP);
        launch();
        lastAddr = `RESET_VECTOR;
        for (i = 0; i < 5; i++) begin
            while (instrAddr == lastAddr)
                @(negedge clk);
            checkValue("instrAddr", instrAddr, lastAddr + 32'd1);
            lastAddr = instrAddr;
        end
    endtask

    task automatic aluOperations();
        logic [31:0] expected [$];
        logic [31:0] x;
        logic [31:0] y;
        logic [11:0] imm;
        aluOp        op;
        int          code;
        int          t;
        int          width;
        int          dataPtr;
        dataPtr = 512;
        emit(encode(0, 0, 0, 4, 0, 0, opOr, resultAddr));   // r4 holds the result address
        for (code = 0; code < 16; code++) begin
            for (t = 0; t < 2; t++) begin
                op    = aluOp'(4'(code));
                width = (op == opShl || op == opShr) ? 6 : 32;  // Amounts reach past 31
                x     = randomBits(32);
                if (t == 0 && (op == opEq || op == opNe))
                    y = x;                                  // Equal operands for the true case
                else
                    y = randomBits(t == 0 ? width : 32);
                imm   = 12'(randomBits((t == 1 && width < 32) ? width : 12));
                writeWord(dataPtr, x);
                writeWord(dataPtr + 1, y);
                emit(encode(0, 0, 1, 1, 0, 0, opOr, dataPtr));
                emit(encode(0, 0, 1, 2, 0, 0, opOr, dataPtr + 1));
                emit(encode(t, 1, 0, 4, 1, 2, op, int'(imm)));
                expected.push_back(aluModel(op, t, x, y, {{20{imm[11]}}, imm}));
                dataPtr += 2;
            end
        end
        launch();
        dataPtr = 512;
        while (expected.size() > 0) begin
            expectAccess(0, dataPtr, '0);
            expectAccess(0, dataPtr + 1, '0);
            expectAccess(1, resultAddr, expected.pop_front());
            dataPtr += 2;
        end
    endtask

    task automatic pseudoRegisters();
        int storeAddr;
        emit(encode(0, 0, 0, 4, 0, 0, opOr, resultAddr));
        emit(encode(0, 0, 0, 0, 0, 0, opOr, 123));          // Write to r0 is dropped
        emit(encode(0, 1, 0, 4, 0, 0, opOr, 0));
        storeAddr = progPtr;
        emit(encode(0, 1, 0, 4, 15, 0, opOr, 0));
        launch();
        expectAccess(1, resultAddr, 32'h0);
        expectAccess(1, resultAddr, 32'(storeAddr + 1));
    endtask

    task automatic loadStoreRoundTrip();
        logic [31:0] word;
        word = randomBits(32);
        writeWord(600, word);
        emit(encode(0, 0, 0, 4, 0, 0, opOr, resultAddr));
        emit(encode(0, 0, 1, 5, 0, 0, opOr, 600));
        emit(encode(0, 1, 1, 5, 0, 0, opOr, 700));          // mem[700] gets r5
        emit(encode(0, 0, 1, 6, 0, 0, opOr, 700));
        emit(encode(0, 1, 0, 4, 6, 0, opOr, 0));            // mem[r4] gets r6
        launch();
        expectAccess(0, 600, '0);
        expectAccess(1, 700, word);
        expectAccess(0, 700, '0);
        expectAccess(1, resultAddr, word);
    endtask

    task automatic branchOverWord();
        int branchAddr;
        emit(encode(0, 0, 0, 4, 0, 0, opOr, resultAddr));
        branchAddr = progPtr;
        emit(encode(0, 0, 0, 15, 15, 0, opAdd, 1));         // Relative jump over one word
        emit(encode(0, 1, 0, 4, 0, 0, opOr, 'h555));
        emit(encode(0, 1, 0, 4, 15, 0, opOr, 0));
        launch();
        while (instrAddr != 32'(branchAddr))
            @(negedge clk);
        while (instrAddr == 32'(branchAddr))
            @(negedge clk);
        checkValue("instrAddr", instrAddr, 32'(branchAddr + 2));
        expectAccess(1, resultAddr, 32'(branchAddr + 3));
    endtask

    task automatic illegalHalt();
        int haltAddr;
        int i;
        haltAddr = progPtr;
        emit(32'hffff_ffff);
        emit(encode(0, 1, 0, 0, 0, 0, opOr, 0));            // Never reached
        launch();
        while (!halt)
            @(negedge clk);
        for (i = 0; i < holdPeriods * `CORE_CPI; i++) begin
            checkValue("strobe", 32'(strobe), 32'h0);
            checkValue("instrAddr", instrAddr, 32'(haltAddr));
            @(negedge clk);
        end
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("timeout: the tests did not finish within %0d cycles", timeoutCycles);
            stopWithFailure();
        end
    end

    initial begin
        loadEnable = 1'b0;
        loadAddr   = '0;
        loadData   = '0;
        lfsrState  = 32'ha0db_eb47;
        progPtr    = 1;
        parkAddr   = 0;
        resetSequence();
        aluOperations();
        pseudoRegisters();
        loadStoreRoundTrip();
        branchOverWord();
        illegalHalt();
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+src
src/isaPkg.sv
src/busPkg.sv
src/instrDecoder.sv
src/registerFile.sv
src/aluExec.sv
src/coreControl.sv
src/coreTop.sv
test/clockGen.sv
test/simMemory.sv
test/coreTb.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"
verilator --binary --timing -sv --top-module coreTb -f project.f -o coreTbSim
./obj_dir/coreTbSim > sim.log 2>&1 || true
cat sim.log

if grep -q "TB FAILED" sim.log || ! grep -q "TB PASSED" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
